// File: sources.f
rtl/periph_pkg.sv
rtl/axil_slave_port.sv
rtl/pad_scanner.sv
rtl/periph_regs.sv
rtl/periph_top.sv
tests/pad_model.sv
tests/tb_periph_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module tb_periph_top -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"

// File: tests/tb_periph_top.sv
// Runs with scan_div_log2 of 3 so a full pad scan takes 80 clocks; fixed random seed
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
	import periph_pkg::*;
;

	localparam int scan_div_log2  = 3;
	localparam int clock_period   = 20;
	localparam int scan_len       = 10 * (1 << scan_div_log2);
	localparam int config_iters   = 12;
	localparam int max_txn_cycles = 12;
	localparam int txn_count      = 2 * config_iters + 30;
	localparam int watchdog_cycles = txn_count * max_txn_cycles + 3 * scan_len + 200;

	logic         clk_50mhz;
	logic         resetn;
	axil_req_t    req;
	axil_rsp_t    rsp;
	logic         pad0_data;
	logic         pad1_data;
	pad_pins_t    pad0_pins;
	pad_pins_t    pad1_pins;
	logic         rotate_video;
	pad_buttons_t btn0;
	pad_buttons_t btn1;
	word_t        exp_cfg [config_words];
	int           seed;
	int           cycle = 0;
	int           errors = 0;
	int           tests_run = 0;

	periph_top #(
		.scan_div_log2 (scan_div_log2)
	) UUT (
		.clk_50mhz    (clk_50mhz),
		.resetn       (resetn),
		.s_axil_req   (req),
		.s_axil_rsp   (rsp),
		.pad0_data    (pad0_data),
		.pad1_data    (pad1_data),
		.pad0_pins    (pad0_pins),
		.pad1_pins    (pad1_pins),
		.rotate_video (rotate_video)
	);

	pad_model pad0 (.clk_50mhz(clk_50mhz), .pins(pad0_pins), .buttons(btn0), .data(pad0_data));
	pad_model pad1 (.clk_50mhz(clk_50mhz), .pins(pad1_pins), .buttons(btn1), .data(pad1_data));

	initial begin
		clk_50mhz = 1'b0;
		forever #(clock_period / 2) clk_50mhz = ~clk_50mhz;
	end

	// Changes on the falling edge so it is stable at the rising edge
	always @(negedge clk_50mhz) begin
		cycle <= cycle + 1;
	end

	initial begin
		#(watchdog_cycles * clock_period);
		$display("watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

	task automatic check_word(input string name, input word_t got, input word_t expected);
		assert (got === expected) else begin
			$display("mismatch %s: got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - errs_before);
		end
	endtask

	function automatic word_t merge_bytes(input word_t old, input word_t data, input strb_t strb);
		word_t merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				merged[8*b +: 8] = data[8*b +: 8];
			end
		end
		return merged;
	endfunction

	// A read is offered during the stall and must not be taken
	task automatic bus_write(input local_addr_t addr, input word_t data, input strb_t strb,
			input int stall, output resp_t resp);
		@(negedge clk_50mhz);
		req.awaddr  = addr;
		req.wdata   = data;
		req.wstrb   = strb;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		@(posedge clk_50mhz);
		while (!(rsp.awready && rsp.wready)) @(posedge clk_50mhz);
		check_true(!rsp.bvalid, "bvalid high in the write acceptance cycle");
		@(negedge clk_50mhz);
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		req.araddr  = addr;
		req.arvalid = 1'b1;
		check_true(rsp.bvalid, "bvalid not high one cycle after write acceptance");
		resp = rsp.bresp;
		repeat (stall) begin
			@(posedge clk_50mhz);
			check_true(rsp.bvalid && rsp.bresp == resp, "write response changed while stalled");
			check_true(!rsp.awready && !rsp.wready && !rsp.arready,
				"address accepted while a write response was pending");
		end
		@(negedge clk_50mhz);
		req.arvalid = 1'b0;
		req.bready  = 1'b1;
		@(posedge clk_50mhz);
		check_true(rsp.bvalid, "bvalid dropped before the handshake");
		@(negedge clk_50mhz);
		req.bready = 1'b0;
		check_true(!rsp.bvalid, "bvalid still high after the handshake");
	endtask

	// A write is offered during the stall and must not be taken
	task automatic bus_read(input local_addr_t addr, input int stall,
			output word_t data, output resp_t resp, output int t_acc);
		@(negedge clk_50mhz);
		req.araddr  = addr;
		req.arvalid = 1'b1;
		@(posedge clk_50mhz);
		while (!rsp.arready) @(posedge clk_50mhz);
		t_acc = cycle;
		check_true(!rsp.rvalid, "rvalid high in the read acceptance cycle");
		@(negedge clk_50mhz);
		req.arvalid = 1'b0;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		check_true(rsp.rvalid, "rvalid not high one cycle after read acceptance");
		data = rsp.rdata;
		resp = rsp.rresp;
		repeat (stall) begin
			@(posedge clk_50mhz);
			check_true(rsp.rvalid && rsp.rdata == data && rsp.rresp == resp,
				"read response changed while stalled");
			check_true(!rsp.awready && !rsp.wready && !rsp.arready,
				"address accepted while a read response was pending");
		end
		@(negedge clk_50mhz);
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		req.rready  = 1'b1;
		@(posedge clk_50mhz);
		check_true(rsp.rvalid, "rvalid dropped before the handshake");
		@(negedge clk_50mhz);
		req.rready = 1'b0;
		check_true(!rsp.rvalid, "rvalid still high after the handshake");
	endtask

	initial begin
		local_addr_t bad_addr [4];
		int          errs;
		int          stall;
		int          idx;
		int          t1;
		int          t2;
		word_t       data;
		word_t       got;
		strb_t       strb;
		resp_t       resp;
		bad_addr = '{12'h000, 12'h100, 12'h500, 12'h440};
		seed   = 23767;
		req    = '0;
		resetn = 1'b0;
		btn0   = '0;
		btn1   = '0;
		for (int i = 0; i < config_words; i++) begin
			exp_cfg[i] = '0;
		end
		repeat (2) @(posedge clk_50mhz);
		@(negedge clk_50mhz);
		resetn = 1'b1;

		errs = errors;
		@(negedge clk_50mhz);
		check_true(!rsp.bvalid && !rsp.rvalid, "response valid high after reset");
		check_true(!rotate_video, "rotate_video high after reset");
		check_true(pad0_pins == '0 && pad1_pins == '0, "pad latch or clock high after reset");
		bus_read(pads_base, 0, got, resp, t1);
		check_word("pad rdata", got, 32'h0);
		report_test("reset state", errs);

		errs = errors;
		for (int i = 0; i < config_iters; i++) begin
			idx   = $unsigned($random(seed)) % config_words;
			data  = $random(seed);
			strb  = strb_t'($random(seed));
			stall = $unsigned($random(seed)) % 6;
			bus_write(config_base + local_addr_t'(idx * 4), data, strb, stall, resp);
			check_word("bresp", word_t'(resp), word_t'(resp_okay));
			exp_cfg[idx] = merge_bytes(exp_cfg[idx], data, strb);
			bus_read(config_base + local_addr_t'(idx * 4), stall, got, resp, t1);
			check_word("config rdata", got, exp_cfg[idx]);
			check_word("rresp", word_t'(resp), word_t'(resp_okay));
		end
		bus_write(config_base, 32'h1, 4'hf, 0, resp);
		exp_cfg[0] = 32'h1;
		check_word("rotate_video", word_t'(rotate_video), 32'h1);
		bus_write(config_base, 32'h0, 4'hf, 0, resp);
		exp_cfg[0] = 32'h0;
		check_word("rotate_video", word_t'(rotate_video), 32'h0);
		report_test("config memory", errs);

		errs = errors;
		btn0 = pad_buttons_t'($random(seed));
		btn1 = pad_buttons_t'($random(seed));
		repeat (3 * scan_len) @(negedge clk_50mhz);
		bus_read(pads_base, 0, got, resp, t1);
		check_word("pad rdata", got, {16'h0000, btn1, btn0});
		check_word("rresp", word_t'(resp), word_t'(resp_okay));
		report_test("game pads", errs);

		errs = errors;
		bus_read(counter_base, 0, data, resp, t1);
		bus_read(counter_base, $unsigned($random(seed)) % 6, got, resp, t2);
		check_word("counter delta", got - data, word_t'(t2 - t1));
		report_test("cycle counter", errs);

		errs = errors;
		foreach (bad_addr[i]) begin
			bus_read(bad_addr[i], 0, got, resp, t1);
			check_word("unmapped rdata", got, 32'h0);
			check_word("unmapped rresp", word_t'(resp), word_t'(resp_slverr));
		end
		bus_write(pads_base, $random(seed), 4'hf, 1, resp);
		check_word("pad bresp", word_t'(resp), word_t'(resp_slverr));
		bus_write(counter_base + 12'h4, $random(seed), 4'hf, 2, resp);
		check_word("counter bresp", word_t'(resp), word_t'(resp_slverr));
		for (int i = 0; i < config_words; i++) begin
			bus_read(config_base + local_addr_t'(i * 4), 0, got, resp, t1);
			check_word("config rdata", got, exp_cfg[i]);
		end
		report_test("error responses", errs);

		$display("tests run: %0d, check errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/pad_model.sv
// Behavioral game pad; no reset, buttons load while latch is high and pins are active low
`timescale 1ns/1ps
`default_nettype none

module pad_model
	import periph_pkg::*;
(
	input  wire logic         clk_50mhz,
	input  wire pad_pins_t    pins,
	input  wire pad_buttons_t buttons,
	output logic              data
);

	pad_buttons_t shift_q = '0;
	logic         clk_q   = 1'b0;

	// Rising pad clock is seen one system clock late
	always @(posedge clk_50mhz) begin
		clk_q <= pins.pad_clk;
		if (pins.pad_latch) begin
			shift_q <= buttons;
		end else if (pins.pad_clk && !clk_q) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	// Pressed button pulls the line low
	assign data = ~shift_q[0];

endmodule

`default_nettype wire

// File: rtl/periph_top.sv
// Peripheral window top; single clock domain, pad data pins are expected already synchronized
`timescale 1ns/1ps
`default_nettype none

module periph_top
	import periph_pkg::*;
#(
	parameter int scan_div_log2 = 9
) (
	input  wire logic      clk_50mhz,
	input  wire logic      resetn,
	input  wire axil_req_t s_axil_req,
	output axil_rsp_t      s_axil_rsp,
	input  wire logic      pad0_data,
	input  wire logic      pad1_data,
	output pad_pins_t      pad0_pins,
	output pad_pins_t      pad1_pins,
	output logic           rotate_video
);

	reg_req_t     reg_req;
	reg_rsp_t     reg_rsp;
	pad_buttons_t pad0_buttons;
	pad_buttons_t pad1_buttons;

	axil_slave_port bus_port (
		.clk_50mhz  (clk_50mhz),
		.resetn     (resetn),
		.s_axil_req (s_axil_req),
		.s_axil_rsp (s_axil_rsp),
		.reg_req    (reg_req),
		.reg_rsp    (reg_rsp)
	);

	// Both pads scanned in lockstep
	pad_scanner #(
		.scan_div_log2 (scan_div_log2)
	) pad0_scan (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.pad_data  (pad0_data),
		.pad_pins  (pad0_pins),
		.buttons   (pad0_buttons)
	);

	pad_scanner #(
		.scan_div_log2 (scan_div_log2)
	) pad1_scan (
		.clk_50mhz (clk_50mhz),
		.resetn    (resetn),
		.pad_data  (pad1_data),
		.pad_pins  (pad1_pins),
		.buttons   (pad1_buttons)
	);

	periph_regs regs (
		.clk_50mhz    (clk_50mhz),
		.resetn       (resetn),
		.reg_req      (reg_req),
		.pad0_buttons (pad0_buttons),
		.pad1_buttons (pad1_buttons),
		.reg_rsp      (reg_rsp),
		.rotate_video (rotate_video)
	);

endmodule

`default_nettype wire

// File: rtl/periph_regs.sv
// Pad and counter regions are read only; config region holds 16 words, addresses past them error
`timescale 1ns/1ps
`default_nettype none

module periph_regs
	import periph_pkg::*;
(
	input  wire logic         clk_50mhz,
	input  wire logic         resetn,
	input  wire reg_req_t     reg_req,
	input  wire pad_buttons_t pad0_buttons,
	input  wire pad_buttons_t pad1_buttons,
	output reg_rsp_t          reg_rsp,
	output logic              rotate_video
);

	localparam int idx_bits = $clog2(config_words);

	region_t             region;
	logic [idx_bits-1:0] cfg_idx;
	logic                cfg_write;
	word_t               cycle_count;
	word_t               cfg_mem [config_words];

	assign cfg_idx = reg_req.addr[idx_bits+1:2];

	// Region decode on the upper nibble
	always_comb begin
		if (reg_req.addr[11:8] == pads_base[11:8]) begin
			region = region_pads;
		end else if (reg_req.addr[11:8] == counter_base[11:8]) begin
			region = region_counter;
		end else if (reg_req.addr[11:8] == config_base[11:8]
			&& reg_req.addr[7:idx_bits+2] == '0) begin
			region = region_config;
		end else begin
			region = region_none;
		end
	end

	assign cfg_write = reg_req.valid && reg_req.write && (region == region_config);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			cycle_count <= '0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			for (int i = 0; i < config_words; i++) begin
				cfg_mem[i] <= '0;
			end
		end else if (cfg_write) begin
			for (int b = 0; b < 4; b++) begin
				if (reg_req.wstrb[b]) begin
					cfg_mem[cfg_idx][8*b +: 8] <= reg_req.wdata[8*b +: 8];
				end
			end
		end
	end

	// Same-cycle answer; errors carry zero data
	always_comb begin
		reg_rsp.rdata = '0;
		reg_rsp.resp  = resp_okay;
		case (region)
			region_pads: begin
				if (reg_req.write) begin
					reg_rsp.resp = resp_slverr;
				end else begin
					reg_rsp.rdata = {16'h0000, pad1_buttons, pad0_buttons};
				end
			end
			region_counter: begin
				if (reg_req.write) begin
					reg_rsp.resp = resp_slverr;
				end else begin
					reg_rsp.rdata = cycle_count;
				end
			end
			region_config: begin
				if (!reg_req.write) begin
					reg_rsp.rdata = cfg_mem[cfg_idx];
				end
			end
			default: begin
				reg_rsp.resp = resp_slverr;
			end
		endcase
	end

	assign rotate_video = cfg_mem[0][0];

endmodule

`default_nettype wire

// File: rtl/pad_scanner.sv
// Serial pad scan of 10 bit periods of 2**scan_div_log2 clocks; scan_div_log2 must be 2 or more
`timescale 1ns/1ps
`default_nettype none

module pad_scanner
	import periph_pkg::*;
#(
	parameter int scan_div_log2 = 9
) (
	input  wire logic clk_50mhz,
	input  wire logic resetn,
	input  wire logic pad_data,
	output pad_pins_t    pad_pins,
	output pad_buttons_t buttons
);

	typedef enum logic [1:0] {
		latch,
		shift,
		gap
	} state_t;

	// Last clock of the low half of a bit period
	localparam logic [scan_div_log2-1:0] sample_point =
		scan_div_log2'((1 << (scan_div_log2 - 1)) - 1);

	state_t                   state;
	logic [scan_div_log2-1:0] div_cnt;
	logic [2:0]               bit_cnt;
	logic                     period_end;
	logic                     sample;
	logic                     scan_done;
	pad_buttons_t             shift_q;

	assign period_end = (div_cnt == '1);
	assign sample     = (state == shift) && (div_cnt == sample_point);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state     <= gap;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			scan_done <= 1'b0;
			buttons   <= '0;
		end else begin
			div_cnt   <= div_cnt + 1'b1;
			scan_done <= sample && (bit_cnt == 3'd7);
			// Pins are active low, so a pressed button reads as 0
			if (scan_done) begin
				buttons <= ~shift_q;
			end
			if (period_end) begin
				case (state)
					latch: state <= shift;
					shift: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= gap;
						end
					end
					default: state <= latch;
				endcase
			end
		end
	end

	// First bit out of the pad ends up in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (sample) begin
			shift_q <= {pad_data, shift_q[7:1]};
		end
	end

	always_comb begin
		pad_pins.pad_latch = (state == latch);
		pad_pins.pad_clk   = (state == shift) && div_cnt[scan_div_log2-1];
	end

endmodule

`default_nettype wire

// File: rtl/axil_slave_port.sv
// One transaction at a time, reads win over writes, AW and W must be offered together
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port
	import periph_pkg::*;
(
	input  wire logic      clk_50mhz,
	input  wire logic      resetn,
	input  wire axil_req_t s_axil_req,
	output axil_rsp_t      s_axil_rsp,
	output reg_req_t       reg_req,
	input  wire reg_rsp_t  reg_rsp
);

	typedef enum logic [1:0] {
		idle,
		write_resp,
		read_resp
	} state_t;

	state_t state;
	logic   rd_accept;
	logic   wr_accept;

	// Held response payload
	resp_t bresp_q;
	resp_t rresp_q;
	word_t rdata_q;

	always_comb begin
		rd_accept = (state == idle) && s_axil_req.arvalid;
		// Write needs both channels at once and loses to a pending read
		wr_accept = (state == idle) && !s_axil_req.arvalid
			&& s_axil_req.awvalid && s_axil_req.wvalid;
	end

	always_comb begin
		reg_req.valid = rd_accept || wr_accept;
		reg_req.write = wr_accept;
		reg_req.addr  = rd_accept ? s_axil_req.araddr : s_axil_req.awaddr;
		reg_req.wdata = s_axil_req.wdata;
		reg_req.wstrb = s_axil_req.wstrb;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (rd_accept) begin
						state <= read_resp;
					end else if (wr_accept) begin
						state <= write_resp;
					end
				end
				write_resp: begin
					if (s_axil_req.bready) begin
						state <= idle;
					end
				end
				read_resp: begin
					if (s_axil_req.rready) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// Register answer arrives in the acceptance cycle
	always_ff @(posedge clk_50mhz) begin
		if (rd_accept) begin
			rdata_q <= reg_rsp.rdata;
			rresp_q <= reg_rsp.resp;
		end
		if (wr_accept) begin
			bresp_q <= reg_rsp.resp;
		end
	end

	always_comb begin
		s_axil_rsp.awready = wr_accept;
		s_axil_rsp.wready  = wr_accept;
		s_axil_rsp.bresp   = bresp_q;
		s_axil_rsp.bvalid  = (state == write_resp);
		s_axil_rsp.arready = rd_accept;
		s_axil_rsp.rdata   = rdata_q;
		s_axil_rsp.rresp   = rresp_q;
		s_axil_rsp.rvalid  = (state == read_resp);
	end

endmodule

`default_nettype wire

// File: rtl/periph_pkg.sv
// Address map and bus types for the peripheral window; 12-bit local addresses, 32-bit data only
`default_nettype none

package periph_pkg;

	typedef logic [11:0] local_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [3:0]  strb_t;
	typedef logic [1:0]  resp_t;
	typedef logic [7:0]  pad_buttons_t;

	localparam resp_t resp_okay   = 2'b00;
	localparam resp_t resp_slverr = 2'b10;

	// Upper four address bits pick the region
	localparam local_addr_t pads_base    = 12'h200;
	localparam local_addr_t counter_base = 12'h300;
	localparam local_addr_t config_base  = 12'h400;

	localparam int config_words = 16;

	typedef enum logic [1:0] {
		region_pads,
		region_counter,
		region_config,
		region_none
	} region_t;

	typedef struct packed {
		logic pad_clk;
		logic pad_latch;
	} pad_pins_t;

	typedef struct packed {
		local_addr_t awaddr;
		logic        awvalid;
		word_t       wdata;
		strb_t       wstrb;
		logic        wvalid;
		logic        bready;
		local_addr_t araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic  awready;
		logic  wready;
		resp_t bresp;
		logic  bvalid;
		logic  arready;
		word_t rdata;
		resp_t rresp;
		logic  rvalid;
	} axil_rsp_t;

	// One-cycle request toward the register block
	typedef struct packed {
		logic        valid;
		logic        write;
		local_addr_t addr;
		word_t       wdata;
		strb_t       wstrb;
	} reg_req_t;

	typedef struct packed {
		word_t rdata;
		resp_t resp;
	} reg_rsp_t;

endpackage

`default_nettype wire
